//--- logic/kotku_pkg.sv
package kotku_pkg;

  // parallel nor flash, byte wide
  localparam int flash_aw = 22;

  // async sram, 16-bit words
  localparam int sram_aw = 18;

  // boot image size in sram words
  localparam int boot_words = 256;

  // two flash bytes per sram word
  localparam logic [flash_aw-1:0] boot_bytes = flash_aw'(2 * boot_words);

  // cycles with output enable low before the byte is sampled
  localparam int flash_wait = 4;

  // wide enough to count down from flash_wait-1
  localparam int wait_cw = (flash_wait > 1) ? $clog2(flash_wait) : 1;

  // flash reader states
  localparam logic [1:0] rd_idle = 2'd0;
  localparam logic [1:0] rd_wait = 2'd1;
  localparam logic [1:0] rd_hold = 2'd2;

  // sram access phases
  localparam logic [1:0] ph_idle  = 2'd0;
  localparam logic [1:0] ph_write = 2'd1;
  localparam logic [1:0] ph_read  = 2'd2;
  localparam logic [1:0] ph_resp  = 2'd3;

  // sram word, seen whole or as its two byte lanes
  typedef union packed {
    logic [15:0] word;
    struct packed {
      logic [7:0] hi;
      logic [7:0] lo;
    } lane;
  } sram_word_t;

endpackage

//--- logic/flash_reader.sv
module flash_reader (
  input  logic                           clk_50,
  input  logic                           arst_n,
  output logic [kotku_pkg::flash_aw-1:0] flash_addr,
  input  logic [7:0]                     flash_data,
  output logic                           flash_oe_n,
  output logic                           flash_rst_n,
  output logic                           byte_valid,
  input  logic                           byte_ready,
  output logic [7:0]                     byte_data
);
  import kotku_pkg::*;

  logic [1:0]         state;
  logic [wait_cw-1:0] wait_cnt;
  logic               more;
  logic               sample;

  // image not yet fully read
  assign more = (flash_addr != boot_bytes);

  // last cycle of the access wait
  assign sample = (state == rd_wait) && (wait_cnt == '0);

  // flash leaves reset one cycle after arst_n
  always_ff @(posedge clk_50 or negedge arst_n)
  begin
    if (!arst_n)
      flash_rst_n <= 1'b0;
    else
      flash_rst_n <= 1'b1;
  end

  always_ff @(posedge clk_50 or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state      <= rd_idle;
      flash_addr <= '0;
      wait_cnt   <= '0;
    end
    else
    begin
      case (state)
        rd_idle:
        begin
          // start only once the part is out of reset
          if (flash_rst_n && more)
          begin
            state    <= rd_wait;
            wait_cnt <= wait_cw'(flash_wait - 1);
          end
        end
        rd_wait:
        begin
          if (sample)
          begin
            state      <= rd_hold;
            // next address set up while the byte waits
            flash_addr <= flash_addr + 1'b1;
          end
          else
            wait_cnt <= wait_cnt - 1'b1;
        end
        rd_hold:
        begin
          if (byte_ready)
          begin
            if (more)
            begin
              state    <= rd_wait;
              wait_cnt <= wait_cw'(flash_wait - 1);
            end
            else
              // whole image handed out, park for good
              state <= rd_idle;
          end
        end
        default:
          state <= rd_idle;
      endcase
    end
  end

  // byte held stable until accepted
  always_ff @(posedge clk_50)
  begin
    if (sample)
      byte_data <= flash_data;
  end

  assign flash_oe_n = (state != rd_wait);
  assign byte_valid = (state == rd_hold);

  // address must not move under an active read
  a_addr_stable: assert property (@(posedge clk_50) disable iff (!arst_n)
    !flash_oe_n |=> flash_oe_n || $stable(flash_addr));

endmodule

//--- logic/boot_copier.sv
module boot_copier (
  input  logic                          clk_50,
  input  logic                          arst_n,
  input  logic                          byte_valid,
  output logic                          byte_ready,
  input  logic [7:0]                    byte_data,
  output logic                          boot_valid,
  input  logic                          boot_ready,
  output logic [kotku_pkg::sram_aw-1:0] boot_addr,
  output logic [15:0]                   boot_wdata,
  output logic                          boot_done
);
  import kotku_pkg::*;

  sram_word_t word_q;
  logic       hi_next;
  logic       byte_take;
  logic       word_take;
  logic       last_word;

  assign byte_take = byte_valid && byte_ready;
  assign word_take = boot_valid && boot_ready;
  assign last_word = (boot_addr == sram_aw'(boot_words - 1));

  // no new bytes while a word is pending or after boot
  assign byte_ready = !boot_valid && !boot_done;

  always_ff @(posedge clk_50 or negedge arst_n)
  begin
    if (!arst_n)
    begin
      hi_next    <= 1'b0;
      boot_valid <= 1'b0;
      boot_addr  <= '0;
      boot_done  <= 1'b0;
    end
    else
    begin
      if (byte_take)
      begin
        hi_next <= !hi_next;
        // second byte completes the word
        if (hi_next)
          boot_valid <= 1'b1;
      end
      if (word_take)
      begin
        boot_valid <= 1'b0;
        if (last_word)
          boot_done <= 1'b1;
        else
          boot_addr <= boot_addr + 1'b1;
      end
    end
  end

  // little endian, even flash byte goes to the low lane
  always_ff @(posedge clk_50)
  begin
    if (byte_take)
    begin
      if (hi_next)
        word_q.lane.hi <= byte_data;
      else
        word_q.lane.lo <= byte_data;
    end
  end

  assign boot_wdata = word_q.word;

  // copier goes quiet once the last write is taken
  a_quiet_after_done: assert property (@(posedge clk_50) disable iff (!arst_n)
    boot_done |-> !boot_valid);

endmodule

//--- logic/sram_ctrl.sv
module sram_ctrl (
  input  logic                          clk_50,
  input  logic                          arst_n,
  input  logic                          boot_done,
  input  logic                          boot_valid,
  output logic                          boot_ready,
  input  logic [kotku_pkg::sram_aw-1:0] boot_addr,
  input  logic [15:0]                   boot_wdata,
  input  logic                          host_valid,
  output logic                          host_ready,
  input  logic                          host_we,
  input  logic [kotku_pkg::sram_aw-1:0] host_addr,
  input  logic [15:0]                   host_wdata,
  input  logic [1:0]                    host_be,
  output logic                          rsp_valid,
  output logic [15:0]                   rsp_data,
  output logic [kotku_pkg::sram_aw-1:0] sram_addr,
  output logic [15:0]                   sram_wdata,
  input  logic [15:0]                   sram_rdata,
  output logic                          sram_we_n,
  output logic                          sram_oe_n,
  output logic                          sram_ce_n,
  output logic [1:0]                    sram_bw_n
);
  import kotku_pkg::*;

  logic [1:0]         phase;
  logic               idle;
  logic               take;
  logic               req_valid;
  logic               req_we;
  logic [sram_aw-1:0] req_addr;
  logic [1:0]         req_be;
  sram_word_t         req_wdata;
  sram_word_t         wdata_q;

  assign idle       = (phase == ph_idle);
  assign boot_ready = idle && !boot_done;
  assign host_ready = idle && boot_done;

  // boot path owns the sram until the image is in
  always_comb
  begin
    if (boot_done)
    begin
      req_valid      = host_valid;
      req_we         = host_we;
      req_addr       = host_addr;
      req_wdata.word = host_wdata;
      req_be         = host_be;
    end
    else
    begin
      req_valid      = boot_valid;
      req_we         = 1'b1;
      req_addr       = boot_addr;
      req_wdata.word = boot_wdata;
      req_be         = 2'b11;
    end
  end

  assign take = idle && req_valid;

  always_ff @(posedge clk_50 or negedge arst_n)
  begin
    if (!arst_n)
    begin
      phase     <= ph_idle;
      sram_we_n <= 1'b1;
      sram_oe_n <= 1'b1;
      sram_ce_n <= 1'b1;
      sram_bw_n <= 2'b11;
    end
    else
    begin
      case (phase)
        ph_idle:
        begin
          if (take)
          begin
            sram_ce_n <= 1'b0;
            if (req_we)
            begin
              phase     <= ph_write;
              sram_we_n <= 1'b0;
              // active low lane selects
              sram_bw_n <= ~req_be;
            end
            else
            begin
              phase     <= ph_read;
              sram_oe_n <= 1'b0;
              sram_bw_n <= 2'b00;
            end
          end
        end
        ph_write:
        begin
          // single cycle write strobe
          phase     <= ph_idle;
          sram_we_n <= 1'b1;
          sram_ce_n <= 1'b1;
          sram_bw_n <= 2'b11;
        end
        ph_read:
        begin
          phase     <= ph_resp;
          sram_oe_n <= 1'b1;
          sram_ce_n <= 1'b1;
          sram_bw_n <= 2'b11;
        end
        default:
          // response cycle, then free again
          phase <= ph_idle;
      endcase
    end
  end

  // address and data set up with the strobe
  always_ff @(posedge clk_50)
  begin
    if (take)
    begin
      sram_addr <= req_addr;
      // only enabled lanes reload, idle lane keeps its old value
      if (req_we && req_be[0])
        wdata_q.lane.lo <= req_wdata.lane.lo;
      if (req_we && req_be[1])
        wdata_q.lane.hi <= req_wdata.lane.hi;
    end
    if (!sram_oe_n)
      rsp_data <= sram_rdata;
  end

  assign sram_wdata = wdata_q.word;
  assign rsp_valid  = (phase == ph_resp);

  // bus never driven both ways at once
  a_we_oe_excl: assert property (@(posedge clk_50) disable iff (!arst_n)
    !(!sram_we_n && !sram_oe_n));

  // fixed read latency seen by the host
  a_rsp_latency: assert property (@(posedge clk_50) disable iff (!arst_n)
    (host_valid && host_ready && !host_we) |-> ##2 rsp_valid);

endmodule

//--- logic/kotku_mem.sv
module kotku_mem (
  input  logic                           clk_50,
  input  logic                           arst_n,
  output logic [kotku_pkg::flash_aw-1:0] flash_addr,
  input  logic [7:0]                     flash_data,
  output logic                           flash_oe_n,
  output logic                           flash_rst_n,
  output logic [kotku_pkg::sram_aw-1:0]  sram_addr,
  output logic [15:0]                    sram_wdata,
  input  logic [15:0]                    sram_rdata,
  output logic                           sram_we_n,
  output logic                           sram_oe_n,
  output logic                           sram_ce_n,
  output logic [1:0]                     sram_bw_n,
  input  logic                           host_valid,
  output logic                           host_ready,
  input  logic                           host_we,
  input  logic [kotku_pkg::sram_aw-1:0]  host_addr,
  input  logic [15:0]                    host_wdata,
  input  logic [1:0]                     host_be,
  output logic                           rsp_valid,
  output logic [15:0]                    rsp_data,
  output logic                           boot_done
);
  import kotku_pkg::*;

  // flash bytes into the copier
  logic               byte_valid;
  logic               byte_ready;
  logic [7:0]         byte_data;

  // packed words into the sram controller
  logic               boot_valid;
  logic               boot_ready;
  logic [sram_aw-1:0] boot_addr;
  logic [15:0]        boot_wdata;

  flash_reader flash_reader_inst (
    .clk_50      (clk_50),
    .arst_n      (arst_n),
    .flash_addr  (flash_addr),
    .flash_data  (flash_data),
    .flash_oe_n  (flash_oe_n),
    .flash_rst_n (flash_rst_n),
    .byte_valid  (byte_valid),
    .byte_ready  (byte_ready),
    .byte_data   (byte_data)
  );

  boot_copier boot_copier_inst (
    .clk_50     (clk_50),
    .arst_n     (arst_n),
    .byte_valid (byte_valid),
    .byte_ready (byte_ready),
    .byte_data  (byte_data),
    .boot_valid (boot_valid),
    .boot_ready (boot_ready),
    .boot_addr  (boot_addr),
    .boot_wdata (boot_wdata),
    .boot_done  (boot_done)
  );

  sram_ctrl sram_ctrl_inst (
    .clk_50     (clk_50),
    .arst_n     (arst_n),
    .boot_done  (boot_done),
    .boot_valid (boot_valid),
    .boot_ready (boot_ready),
    .boot_addr  (boot_addr),
    .boot_wdata (boot_wdata),
    .host_valid (host_valid),
    .host_ready (host_ready),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_be    (host_be),
    .rsp_valid  (rsp_valid),
    .rsp_data   (rsp_data),
    .sram_addr  (sram_addr),
    .sram_wdata (sram_wdata),
    .sram_rdata (sram_rdata),
    .sram_we_n  (sram_we_n),
    .sram_oe_n  (sram_oe_n),
    .sram_ce_n  (sram_ce_n),
    .sram_bw_n  (sram_bw_n)
  );

endmodule

//--- test/mem_models.sv
// byte wide nor flash, read only
module flash_model (
  input  logic [kotku_pkg::flash_aw-1:0] flash_addr,
  output logic [7:0]                     flash_data,
  input  logic                           flash_oe_n,
  input  logic                           flash_rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  // contents follow the low address byte, bus floats high when not driven
  assign flash_data = (!flash_oe_n && flash_rst_n) ? flash_addr[7:0] * 8'h1d + 8'h5a : 8'hff;

endmodule

// async sram, 16-bit words with two lane enables
module sram_model (
  input  logic                          clk_50,
  input  logic [kotku_pkg::sram_aw-1:0] sram_addr,
  input  logic [15:0]                   sram_wdata,
  output logic [15:0]                   sram_rdata,
  input  logic                          sram_we_n,
  input  logic                          sram_oe_n,
  input  logic                          sram_ce_n,
  input  logic [1:0]                    sram_bw_n
);
  timeunit 1ns;
  timeprecision 100ps;
  import kotku_pkg::*;

  logic [15:0] mem [0:(1 << sram_aw)-1];

  // power-up contents, spread over the whole address
  function automatic logic [15:0] fill_word(input int unsigned a);
    return 16'((a * 32'h9e37_79b9) >> 16);
  endfunction

  initial
  begin
    for (int i = 0; i < (1 << sram_aw); i++)
      mem[sram_aw'(i)] = fill_word(i);
  end

  // write strobe sampled on the clock, write and read cycles never overlap
  always @(posedge clk_50)
  begin
    if (!sram_ce_n && !sram_we_n)
    begin
      if (!sram_bw_n[0])
        mem[sram_addr][7:0] = sram_wdata[7:0];
      if (!sram_bw_n[1])
        mem[sram_addr][15:8] = sram_wdata[15:8];
    end
  end

  assign sram_rdata = (!sram_ce_n && !sram_oe_n) ? mem[sram_addr] : 16'h0000;

endmodule

//--- test/tb_kotku_mem.sv
module tb_kotku_mem;
  timeunit 1ns;
  timeprecision 100ps;
  import kotku_pkg::*;

  localparam int host_ops     = 400;
  localparam int limit_cycles = 2 * boot_words * (flash_wait + 3) + host_ops * 6;

  logic                clk_50 = 1'b0;
  logic                arst_n = 1'b0;
  logic [flash_aw-1:0] flash_addr;
  logic [7:0]          flash_data;
  logic                flash_oe_n;
  logic                flash_rst_n;
  logic [sram_aw-1:0]  sram_addr;
  logic [15:0]         sram_wdata;
  logic [15:0]         sram_rdata;
  logic                sram_we_n;
  logic                sram_oe_n;
  logic                sram_ce_n;
  logic [1:0]          sram_bw_n;
  logic                host_valid = 1'b0;
  logic                host_ready;
  logic                host_we = 1'b0;
  logic [sram_aw-1:0]  host_addr = '0;
  logic [15:0]         host_wdata = 16'h0000;
  logic [1:0]          host_be = 2'b00;
  logic                rsp_valid;
  logic [15:0]         rsp_data;
  logic                boot_done;

  // expected sram contents over the 1k test window
  logic [15:0]         shadow [0:1023];
  // read accepted one and two negedges ago
  logic [1:0]          read_pipe = 2'b00;

  kotku_mem kotku_mem_inst (.*);

  flash_model flash_model_inst (.*);

  sram_model sram_model_inst (.*);

  always #20 clk_50 = ~clk_50;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // flash byte at an address
  function automatic logic [7:0] flash_byte(input int unsigned a);
    logic [7:0] lo;
    lo = a[7:0];
    return lo * 8'h1d + 8'h5a;
  endfunction

  // sram power-up word
  function automatic logic [15:0] initial_word(input int unsigned a);
    return 16'((a * 32'h9e37_79b9) >> 16);
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got == exp)
    else
    begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] exp);
    assert (got == exp)
    else
    begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  // every strobe and handshake at rest
  task automatic check_idle_outputs();
    check_bit("flash_oe_n", flash_oe_n, 1'b1);
    check_bit("sram_we_n", sram_we_n, 1'b1);
    check_bit("sram_oe_n", sram_oe_n, 1'b1);
    check_bit("sram_ce_n", sram_ce_n, 1'b1);
    check_word("sram_bw_n", 16'(sram_bw_n), 16'h0003);
    check_bit("byte_valid", kotku_mem_inst.byte_valid, 1'b0);
    check_bit("boot_valid", kotku_mem_inst.boot_valid, 1'b0);
    check_bit("rsp_valid", rsp_valid, 1'b0);
    check_bit("host_ready", host_ready, 1'b0);
    check_bit("boot_done", boot_done, 1'b0);
  endtask

  // one host request with read data checked against the shadow
  task automatic host_access(input logic we, input logic [9:0] addr,
                             input logic [15:0] wdata, input logic [1:0] be);
    logic [15:0] expect_word;
    @(posedge clk_50);
    #2;
    host_valid = 1'b1;
    host_we    = we;
    host_addr  = sram_aw'(addr);
    host_wdata = wdata;
    host_be    = be;
    @(negedge clk_50);
    while (!host_ready)
      @(negedge clk_50);
    // accepted on this edge
    @(posedge clk_50);
    #2;
    host_valid = 1'b0;
    if (we)
    begin
      if (be[0])
        shadow[addr][7:0] = wdata[7:0];
      if (be[1])
        shadow[addr][15:8] = wdata[15:8];
    end
    else
    begin
      expect_word = shadow[addr];
      @(negedge clk_50);
      @(negedge clk_50);
      check_word("rsp_data", rsp_data, expect_word);
    end
  endtask

  // host held off during boot and responses only two cycles after a read
  always @(negedge clk_50)
  begin
    if (arst_n)
    begin
      if (!boot_done)
        check_bit("host_ready", host_ready, 1'b0);
      check_bit("rsp_valid", rsp_valid, read_pipe[1]);
      read_pipe = {read_pipe[0], host_valid && host_ready && !host_we};
    end
    else
      read_pipe = 2'b00;
  end

  initial
  begin
    #(limit_cycles * 40);
    $display("timeout, run did not complete within %0d cycles", limit_cycles);
    $display("TEST FAIL");
    $fatal(1);
  end

  initial
  begin
    logic [31:0] rnd;
    logic        we;
    logic [1:0]  be;
    logic [9:0]  addr;
    rnd = 32'hc5a6_2429;
    // boot image packed little endian and the rest at power-up values
    for (int i = 0; i < 1024; i++)
    begin
      if (i < boot_words)
        shadow[10'(i)] = {flash_byte(2 * i + 1), flash_byte(2 * i)};
      else
        shadow[10'(i)] = initial_word(i);
    end
    repeat (5) @(posedge clk_50);
    @(negedge clk_50);
    check_idle_outputs();
    check_bit("flash_rst_n", flash_rst_n, 1'b0);
    repeat (5) @(posedge clk_50);
    #2;
    arst_n = 1'b1;
    @(negedge clk_50);
    check_idle_outputs();
    // flash still held in reset until the next edge
    check_bit("flash_rst_n", flash_rst_n, 1'b0);
    @(posedge clk_50);
    @(negedge clk_50);
    check_idle_outputs();
    check_bit("flash_rst_n", flash_rst_n, 1'b1);
    while (!boot_done)
      @(negedge clk_50);
    // whole boot image back through the host port
    for (int n = 0; n < boot_words; n++)
      host_access(1'b0, 10'(n), 16'h0000, 2'b00);
    for (int k = 0; k < host_ops; k++)
    begin
      rnd  = xorshift(rnd);
      we   = rnd[0];
      be   = rnd[2:1];
      addr = rnd[12:3];
      rnd  = xorshift(rnd);
      host_access(we, addr, rnd[15:0], be);
    end
    repeat (3) @(negedge clk_50);
    $display("TEST PASS");
    $finish;
  end

endmodule

//--- src.f
logic/kotku_pkg.sv
logic/flash_reader.sv
logic/boot_copier.sv
logic/sram_ctrl.sv
logic/kotku_mem.sv
test/mem_models.sv
test/tb_kotku_mem.sv

//--- Makefile
TOP = tb_kotku_mem

SRCS = $(wildcard logic/*.sv) $(wildcard test/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --assert logic/kotku_pkg.sv logic/flash_reader.sv \
		logic/boot_copier.sv logic/sram_ctrl.sv logic/kotku_mem.sv --top-module kotku_mem
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

obj_dir/V$(TOP): src.f $(SRCS)
	verilator --binary --timing --assert -j 0 -f src.f --top-module $(TOP)

# exit status of the simulator is the test result
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
